/* src/rfObsPkg.sv */
// shared types for the register-file macro with its observation path
// holds the Wishbone request and response structs, the address union,
// the status-register selectors and the observation-width helper
// modules pull these in with a wildcard import in their header

package rfObsPkg;

  // --------------------------------------------------
  // bus widths
  // --------------------------------------------------

  // Wishbone data width, fixed for the whole macro
  localparam int dataWidth = 32;
  // address bit 7 picks the space: 0 is the array, 1 is the status block
  localparam int addrWidth = 8;

  // --------------------------------------------------
  // address decode views
  // --------------------------------------------------

  // array view, only the low indexWidth bits of the index reach the array
  typedef struct packed {
    logic                 space;
    logic [addrWidth-2:0] index;
  } arrayView_t;

  // status view, the low bits select one status register
  typedef struct packed {
    logic                 space;
    logic [addrWidth-2:0] csrSel;
  } csrView_t;

  // the same address word read two ways depending on the space bit
  typedef union packed {
    arrayView_t arrayView;
    csrView_t   csrView;
  } wbAddr_u;

  // status register selectors, the testbench uses them as well
  localparam logic [addrWidth-2:0] csrObs   = 7'd0;
  localparam logic [addrWidth-2:0] csrCount = 7'd1;

  // --------------------------------------------------
  // Wishbone classic request and response
  // --------------------------------------------------

  typedef struct packed {
    logic                   cyc;
    logic                   stb;
    logic                   we;
    logic [dataWidth/8-1:0] sel;
    wbAddr_u                adr;
    logic [dataWidth-1:0]   dat;
  } wbReq_t;

  typedef struct packed {
    logic                 ack;
    logic [dataWidth-1:0] dat;
  } wbRsp_t;

  // number of XOR groups over a vector, a partial last group counts as one
  function automatic int obsFlopNum(input int pinNum, input int xorSize);
    return (pinNum / xorSize) + int'((pinNum % xorSize) > 0);
  endfunction

endpackage

/* src/rfArray.sv */
// one-read one-write storage array behind the Wishbone slave
// a write updates only the byte lanes whose sel bit is set
// a read loads the addressed word into a register, so data shows up
// one cycle after the accept edge, in step with the acknowledge
// the depth is two to the power of indexWidth words of dataWidth bits

`timescale 1ns/1ps

module rfArray
  import rfObsPkg::*;
#(
  parameter int indexWidth = 4
)
(
  input  logic                   clock,
  input  logic                   arstN,
  input  logic                   enable,
  input  logic                   write,
  input  logic [dataWidth/8-1:0] sel,
  input  logic [indexWidth-1:0]  index,
  input  logic [dataWidth-1:0]   writeData,
  output logic [dataWidth-1:0]   readData
);

  // number of words held by the array
  localparam int depth = 2 ** indexWidth;

  // --------------------------------------------------
  // storage
  // --------------------------------------------------

  logic [dataWidth-1:0] mem [depth];

  // registered read word, cleared at reset so the first response is known
  logic [dataWidth-1:0] readReg;

  // contents are never cleared, software has to write before it reads
  always_ff @(posedge clock)
  begin
    if (enable && write)
    begin
      // each sel bit guards its own byte lane
      for (int lane = 0; lane < dataWidth / 8; lane++)
      begin
        if (sel[lane])
        begin
          mem[index][lane*8 +: 8] <= writeData[lane*8 +: 8];
        end
      end
    end
  end

  // --------------------------------------------------
  // read register
  // --------------------------------------------------

  // the read samples at the same edge a write would land
  // on a write the register keeps its old value
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      readReg <= '0;
    end
    else if (enable && !write)
    begin
      readReg <= mem[index];
    end
  end

  // the responder picks this up while ack is high
  assign readData = readReg;

endmodule

/* src/obsCompactor.sv */
// observation compactor for the array's address and control pins
// the control vector of each array access is folded into XOR groups
// of obsXorSize bits, and the groups are captured in observation flops
// the flops only load on a fired access, so they always show the last one
// a 16-bit wrapping counter keeps track of how many accesses fired

`timescale 1ns/1ps

module obsCompactor
  import rfObsPkg::*;
#(
  parameter int indexWidth = 4,
  parameter int obsXorSize = 3
)
(
  input  logic                                               clock,
  input  logic                                               arstN,
  input  logic                                               accessFire,
  input  logic [indexWidth+4:0]                              accessVec,
  output logic [obsFlopNum(indexWidth + 5, obsXorSize)-1:0] obsSnap,
  output logic [15:0]                                        accessCount
);

  // index plus we plus four sel bits
  localparam int pinNum  = indexWidth + 5;
  localparam int flopNum = obsFlopNum(pinNum, obsXorSize);

  // --------------------------------------------------
  // XOR grouping
  // --------------------------------------------------

  logic [flopNum-1:0] groupBits;

  // group k folds bits k*obsXorSize upward, the last one takes what is left
  for (genvar g = 0; g < flopNum; g++)
  begin : gObsGroup
    if (g < flopNum - 1)
    begin : gFull
      assign groupBits[g] = ^accessVec[g*obsXorSize +: obsXorSize];
    end
    else
    begin : gLast
      // may be shorter than obsXorSize when the width does not divide evenly
      assign groupBits[g] = ^accessVec[pinNum-1 : g*obsXorSize];
    end
  end

  // --------------------------------------------------
  // observation flops and access counter
  // --------------------------------------------------

  logic [flopNum-1:0] obsFlops;
  logic [15:0]        countReg;

  // both update at the accept edge, the next access reads the new values
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      obsFlops <= '0;
      countReg <= '0;
    end
    else if (accessFire)
    begin
      obsFlops <= groupBits;
      // plain increment, the counter rolls over past 16'hffff
      countReg <= countReg + 16'd1;
    end
  end

  assign obsSnap     = obsFlops;
  assign accessCount = countReg;

endmodule

/* src/wbResponder.sv */
// Wishbone classic slave for the register-file macro
// it finds the accept event, decodes the address through the address union
// and steers array accesses to the array and to the observation compactor
// status reads are registered here, and ack follows one cycle after accept
// the response data comes from the array or from the status word,
// depending on which space the last access used

`timescale 1ns/1ps

module wbResponder
  import rfObsPkg::*;
#(
  parameter int indexWidth = 4,
  parameter int obsXorSize = 3
)
(
  input  logic                                               clock,
  input  logic                                               arstN,
  input  wbReq_t                                             req,
  output wbRsp_t                                             rsp,
  output logic                                               arrayEnable,
  output logic                                               arrayWrite,
  output logic [dataWidth/8-1:0]                             arraySel,
  output logic [indexWidth-1:0]                              arrayIndex,
  output logic [dataWidth-1:0]                               arrayWriteData,
  input  logic [dataWidth-1:0]                               readData,
  output logic                                               accessFire,
  output logic [indexWidth+4:0]                              accessVec,
  input  logic [obsFlopNum(indexWidth + 5, obsXorSize)-1:0] obsSnap,
  input  logic [15:0]                                        accessCount
);

  // --------------------------------------------------
  // accept and decode
  // --------------------------------------------------

  logic                 ackReg;
  logic                 csrHit;
  logic [dataWidth-1:0] csrData;
  logic [dataWidth-1:0] csrNext;
  logic                 accept;
  logic                 arraySpace;

  // first edge with a valid request that has not been answered yet
  assign accept = req.cyc && req.stb && !ackReg;

  // space bit 0 means the storage array
  assign arraySpace = !req.adr.arrayView.space;

  // array pins follow the request, enable only pulses at accept
  assign arrayEnable    = accept && arraySpace;
  assign arrayWrite     = req.we;
  assign arraySel       = req.sel;
  assign arrayIndex     = req.adr.arrayView.index[indexWidth-1:0];
  assign arrayWriteData = req.dat;

  // the compactor sees exactly what the array pins see
  // packed as index in the low bits, then we, then sel on top
  assign accessFire = arrayEnable;
  assign accessVec  = {req.sel, req.we, arrayIndex};

  // --------------------------------------------------
  // status register select
  // --------------------------------------------------

  // both status values are zero-extended to the bus width
  always_comb
  begin
    case (req.adr.csrView.csrSel)
      csrObs:   csrNext = dataWidth'(obsSnap);
      csrCount: csrNext = dataWidth'(accessCount);
      // selectors without a register read back as zero
      default:  csrNext = '0;
    endcase
  end

  // status word only loads on a status read, writes there are dropped
  always_ff @(posedge clock)
  begin
    if (accept && !arraySpace && !req.we)
    begin
      csrData <= csrNext;
    end
  end

  // --------------------------------------------------
  // acknowledge and response
  // --------------------------------------------------

  // ack is a single-cycle pulse, it blocks a second accept on the next edge
  // csrHit remembers the space so the response mux stays steady under ack
  always_ff @(posedge clock or negedge arstN)
  begin
    if (!arstN)
    begin
      ackReg <= 1'b0;
      csrHit <= 1'b0;
    end
    else
    begin
      ackReg <= accept;
      if (accept)
      begin
        csrHit <= !arraySpace;
      end
    end
  end

  assign rsp.ack = ackReg;
  assign rsp.dat = csrHit ? csrData : readData;

endmodule

/* src/rfObsTop.sv */
// top level of the register-file macro with its observation path
// a Wishbone classic request comes in, a response with ack goes out
// the storage array and the observation compactor run side by side,
// both fed by the responder, which also merges their results
// indexWidth sets the array depth, obsXorSize the compactor group size,
// and both are handed down to the blocks from here

`timescale 1ns/1ps

module rfObsTop
  import rfObsPkg::*;
#(
  parameter int indexWidth = 4,
  parameter int obsXorSize = 3
)
(
  input  logic   clock,
  input  logic   arstN,
  input  wbReq_t req,
  output wbRsp_t rsp
);

  // number of observation flops for the default control vector
  localparam int flopNum = obsFlopNum(indexWidth + 5, obsXorSize);

  // --------------------------------------------------
  // internal nets
  // --------------------------------------------------

  // array side
  logic                   arrayEnable;
  logic                   arrayWrite;
  logic [dataWidth/8-1:0] arraySel;
  logic [indexWidth-1:0]  arrayIndex;
  logic [dataWidth-1:0]   arrayWriteData;
  logic [dataWidth-1:0]   readData;

  // observation side
  logic                   accessFire;
  logic [indexWidth+4:0]  accessVec;
  logic [flopNum-1:0]     obsSnap;
  logic [15:0]            accessCount;

  // --------------------------------------------------
  // blocks
  // --------------------------------------------------

  rfArray #(
    .indexWidth (indexWidth)
  ) i_rfArray (
    .clock     (clock),
    .arstN     (arstN),
    .enable    (arrayEnable),
    .write     (arrayWrite),
    .sel       (arraySel),
    .index     (arrayIndex),
    .writeData (arrayWriteData),
    .readData  (readData)
  );

  obsCompactor #(
    .indexWidth (indexWidth),
    .obsXorSize (obsXorSize)
  ) i_obsCompactor (
    .clock       (clock),
    .arstN       (arstN),
    .accessFire  (accessFire),
    .accessVec   (accessVec),
    .obsSnap     (obsSnap),
    .accessCount (accessCount)
  );

  // the responder needs obsXorSize only to size its obsSnap input
  wbResponder #(
    .indexWidth (indexWidth),
    .obsXorSize (obsXorSize)
  ) i_wbResponder (
    .clock          (clock),
    .arstN          (arstN),
    .req            (req),
    .rsp            (rsp),
    .arrayEnable    (arrayEnable),
    .arrayWrite     (arrayWrite),
    .arraySel       (arraySel),
    .arrayIndex     (arrayIndex),
    .arrayWriteData (arrayWriteData),
    .readData       (readData),
    .accessFire     (accessFire),
    .accessVec      (accessVec),
    .obsSnap        (obsSnap),
    .accessCount    (accessCount)
  );

endmodule

/* tb/rfObsTop_assertions.sv */
// concurrent checks on the Wishbone classic handshake of the macro
// bound into rfObsTop, so it watches the top-level request and response
// a failing property reports through $error only

`timescale 1ns/1ps

module rfObsTop_assertions
  import rfObsPkg::*;
(
  input logic   clock,
  input logic   arstN,
  input wbReq_t req,
  input wbRsp_t rsp
);

  // same accept event as the slave, a valid request not yet answered
  logic accept;

  assign accept = req.cyc && req.stb && !rsp.ack;

  // ack is a one-cycle pulse
  ackSingle: assert property (@(posedge clock) disable iff (!arstN)
    rsp.ack |=> !rsp.ack)
    else $error("ack stayed high for two cycles");

  // every accept gets its ack on the next edge
  ackAfterAccept: assert property (@(posedge clock) disable iff (!arstN)
    accept |=> rsp.ack)
    else $error("accepted request got no ack one cycle later");

  // and there is no ack without an accept in the cycle before
  ackOnlyAfterAccept: assert property (@(posedge clock) disable iff (!arstN)
    !accept |=> !rsp.ack)
    else $error("ack without an accept in the previous cycle");

  // reset holds ack down
  ackLowInReset: assert property (@(posedge clock) !arstN |-> !rsp.ack)
    else $error("ack high while reset is asserted");

endmodule

bind rfObsTop rfObsTop_assertions i_assertions (
  .clock (clock),
  .arstN (arstN),
  .req   (req),
  .rsp   (rsp)
);

/* tb/rfObsTb.sv */
// testbench for the register-file macro with its observation path
// a table of Wishbone classic accesses is built first and then run in a loop
// each response is compared with a reference model of the array,
// the XOR-group observation value and the access counter
// random data and sel come from a Galois LFSR with a fixed seed

`timescale 1ns/1ps

module rfObsTb
  import rfObsPkg::*;
;

  localparam int indexWidth = 4;
  localparam int obsXorSize = 3;
  localparam int depth      = 2 ** indexWidth;
  localparam int vecWidth   = indexWidth + 5;
  localparam int obsWidth   = (vecWidth + obsXorSize - 1) / obsXorSize;
  localparam int ackLimit   = 8;
  localparam logic [31:0] lfsrTaps = 32'ha3000000;

  typedef enum logic [2:0] {expNone, expMem, expObs, expCount, expZero} expMode_t;

  // each table row holds everything but the name, which lives in a parallel queue
  typedef struct packed {
    logic        write;
    logic        space;
    logic [6:0]  target;
    logic [3:0]  sel;
    logic [31:0] data;
    expMode_t    mode;
  } stimEntry_t;

  logic   clock = 1'b0;
  logic   arstN;
  wbReq_t req;
  wbRsp_t rsp;

  stimEntry_t         stimTable [$];
  string              stimName [$];
  bit                 tableBuilt = 1'b0;
  logic [31:0]        lfsrState  = 32'he87a3caa;
  logic [31:0]        modelMem [depth];
  logic [obsWidth-1:0] modelObs;
  logic [15:0]        modelCount;
  int                 valueErrors    = 0;
  int                 protocolErrors = 0;
  int                 checksRun      = 0;

  rfObsTop #(
    .indexWidth (indexWidth),
    .obsXorSize (obsXorSize)
  ) i_dut (
    .clock (clock),
    .arstN (arstN),
    .req   (req),
    .rsp   (rsp)
  );

  always #2 clock = ~clock;

  // --------------------------------------------------
  // random source and reference model
  // --------------------------------------------------

  function automatic logic [31:0] galoisStep(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0])
    begin
      next = next ^ lfsrTaps;
    end
    return next;
  endfunction

  // one LFSR step per bit handed out
  function automatic logic [31:0] takeBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int b = 0; b < count; b++)
    begin
      value = {value[30:0], lfsrState[0]};
      lfsrState = galoisStep(lfsrState);
    end
    return value;
  endfunction

  // bit b lands in group b / obsXorSize, so the last group takes the leftovers
  function automatic logic [obsWidth-1:0] foldVector(input logic [vecWidth-1:0] vec);
    logic [obsWidth-1:0] folded;
    folded = '0;
    for (int b = 0; b < vecWidth; b++)
    begin
      folded[b / obsXorSize] = folded[b / obsXorSize] ^ vec[b];
    end
    return folded;
  endfunction

  task automatic addEntry(input string name, input logic write, input logic space,
                          input logic [6:0] target, input logic [3:0] sel,
                          input logic [31:0] data, input expMode_t mode);
    stimTable.push_back('{write, space, target, sel, data, mode});
    stimName.push_back(name);
  endtask

  // --------------------------------------------------
  // one Wishbone classic cycle with its checks
  // --------------------------------------------------

  task automatic runEntry(input string name, input stimEntry_t e);
    logic [31:0]         expected;
    logic [vecWidth-1:0] vec;
    int                  waited;
    logic                gotAck;
    // the expected word comes from the model state before this access
    case (e.mode)
      expMem:   expected = modelMem[e.target[indexWidth-1:0]];
      expObs:   expected = 32'(modelObs);
      expCount: expected = 32'(modelCount);
      default:  expected = '0;
    endcase
    @(posedge clock);
    req.cyc <= 1'b1;
    req.stb <= 1'b1;
    req.we  <= e.write;
    req.sel <= e.sel;
    req.dat <= e.data;
    if (e.space)
    begin
      req.adr.csrView.space  <= 1'b1;
      req.adr.csrView.csrSel <= e.target;
    end
    else
    begin
      req.adr.arrayView.space <= 1'b0;
      req.adr.arrayView.index <= e.target;
    end
    // sampling happens at falling edges and the accept edge is the next rising one
    waited = 0;
    gotAck = 1'b0;
    while (!gotAck && waited < ackLimit)
    begin
      @(negedge clock);
      waited++;
      gotAck = rsp.ack;
    end
    checksRun++;
    if (!gotAck)
    begin
      $display("test %s got no acknowledge within %0d cycles", name, ackLimit);
      protocolErrors++;
    end
    else
    begin
      if (waited != 2)
      begin
        $display("[FAIL] %s ack latency expected 2 actual %0d", name, waited);
        valueErrors++;
      end
      if (e.mode != expNone && rsp.dat !== expected)
      begin
        $display("[FAIL] %s expected %h actual %h", name, expected, rsp.dat);
        valueErrors++;
      end
    end
    // status accesses leave the observation path alone
    if (!e.space)
    begin
      if (e.write)
      begin
        for (int lane = 0; lane < 4; lane++)
        begin
          if (e.sel[lane])
          begin
            modelMem[e.target[indexWidth-1:0]][lane*8 +: 8] = e.data[lane*8 +: 8];
          end
        end
      end
      vec = {e.sel, e.write, e.target[indexWidth-1:0]};
      modelObs = foldVector(vec);
      modelCount = modelCount + 16'd1;
    end
    @(posedge clock);
    req.cyc <= 1'b0;
    req.stb <= 1'b0;
    req.we  <= 1'b0;
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------

  initial
  begin
    wait (tableBuilt);
    repeat (stimTable.size() * 10 + 3 + 4) @(posedge clock);
    $display("watchdog expired before the table finished");
    $display("Checks failed");
    $finish;
  end

  // --------------------------------------------------
  // table and main sequence
  // --------------------------------------------------

  initial
  begin
    logic [3:0] partSel [4];
    arstN <= 1'b0;
    req   <= '0;
    modelObs   = '0;
    modelCount = '0;
    partSel = '{4'b0001, 4'b0110, 4'b1000, 4'b1010};

    // both status registers must read zero straight out of reset
    addEntry("resetObs", 1'b0, 1'b1, csrObs, 4'hf, '0, expZero);
    addEntry("resetCount", 1'b0, 1'b1, csrCount, 4'hf, '0, expZero);
    for (int i = 0; i < depth; i++)
    begin
      addEntry($sformatf("fullWrite%0d", i), 1'b1, 1'b0, 7'(i), 4'hf, takeBits(32), expNone);
    end
    for (int i = 0; i < depth; i++)
    begin
      addEntry($sformatf("fullRead%0d", i), 1'b0, 1'b0, 7'(i), 4'hf, '0, expMem);
    end
    // partial lane writes on a few indices are each followed by a read back
    for (int i = 0; i < 4; i++)
    begin
      addEntry($sformatf("partWrite%0d", i), 1'b1, 1'b0, 7'(i * 4 + 1), partSel[i],
               takeBits(32), expNone);
      addEntry($sformatf("partRead%0d", i), 1'b0, 1'b0, 7'(i * 4 + 1), 4'hf, '0, expMem);
    end
    // every random array access gets observed through csrObs
    for (int i = 0; i < 8; i++)
    begin
      addEntry($sformatf("randAccess%0d", i), 1'(takeBits(1)), 1'b0,
               7'(takeBits(indexWidth)), 4'(takeBits(4)), takeBits(32), expNone);
      addEntry($sformatf("randObs%0d", i), 1'b0, 1'b1, csrObs, 4'hf, '0, expObs);
    end
    addEntry("countRead", 1'b0, 1'b1, csrCount, 4'hf, '0, expCount);
    // a selector without a register reads zero while obs and count hold live values
    addEntry("unusedSel", 1'b0, 1'b1, 7'd5, 4'hf, '0, expZero);
    // writes to the status block are acknowledged and change nothing
    addEntry("csrWriteObs", 1'b1, 1'b1, csrObs, 4'hf, takeBits(32), expNone);
    addEntry("csrWriteCount", 1'b1, 1'b1, csrCount, 4'hf, takeBits(32), expNone);
    addEntry("obsAfterCsrWrite", 1'b0, 1'b1, csrObs, 4'hf, '0, expObs);
    addEntry("countAfterCsrWrite", 1'b0, 1'b1, csrCount, 4'hf, '0, expCount);
    tableBuilt = 1'b1;

    repeat (3) @(posedge clock);
    arstN <= 1'b1;
    foreach (stimTable[i])
    begin
      runEntry(stimName[i], stimTable[i]);
    end

    repeat (2) @(posedge clock);
    $display("checks %0d, value errors %0d, protocol errors %0d",
             checksRun, valueErrors, protocolErrors);
    if (valueErrors == 0 && protocolErrors == 0)
    begin
      $display("All checks passed");
    end
    else
    begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* rfObsTop.f */
src/rfObsPkg.sv
src/rfArray.sv
src/obsCompactor.sv
src/wbResponder.sv
src/rfObsTop.sv
tb/rfObsTop_assertions.sv
tb/rfObsTb.sv

/* Makefile */
# Verilator build for the register-file macro and its testbench

TOOL       = verilator
TOP        = rfObsTb
RTL_TOP    = rfObsTop
FILELIST   = rfObsTop.f
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
RTL_SRCS   = $(shell grep '^src/' $(FILELIST))
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = All checks passed

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(RTL_SRCS) --top-module $(RTL_TOP)
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
